// ==== design/slicePkg.sv ====
// Field encodings follow the 2901 microword layout; carry and overflow mean something only for arithmetic functions
`default_nettype none

package slicePkg;

    // Bits per slice; the lookahead terms inside bitSlice assume 4
    localparam int sliceWidth = 4;
    // 16-word register file
    localparam int regAddrWidth = 4;
    // Source in [2:0], function in [5:3], destination in [8:6]
    localparam int instrWidth = 9;

    // R and S operand pairs, named R then S
    typedef enum logic [2:0] {
        srcAQ,
        srcAB,
        srcZQ,
        srcZB,
        srcZA,
        srcDA,
        srcDQ,
        srcDZ
    } aluSrcE;

    // SUBR is S minus R, SUBS is R minus S
    typedef enum logic [2:0] {
        fnAdd,
        fnSubr,
        fnSubs,
        fnOr,
        fnAnd,
        fnNotRs,
        fnExor,
        fnExnor
    } aluFuncE;

    // D suffix shifts down (toward bit 0), U suffix shifts up
    typedef enum logic [2:0] {
        dstQReg,
        dstNop,
        dstRamA,
        dstRamF,
        dstRamQD,
        dstRamD,
        dstRamQU,
        dstRamU
    } aluDestE;

    // Registered result flags
    typedef struct packed {
        logic carry;
        logic overflow;
        logic zero;
        logic sign;
    } statusFlagsT;

endpackage

`default_nettype wire

// ==== design/sliceCtrlIf.sv ====
// Holds the latched microword shared by every slice; writeEn is a one-cycle strobe and the interface has no clock
`timescale 1ns/1ps
`default_nettype none

interface sliceCtrlIf ();
    import slicePkg::*;

    // Latched 9-bit instruction
    logic [instrWidth-1:0] instr;
    // A is read only, B is read and written
    logic [regAddrWidth-1:0] aAddr;
    logic [regAddrWidth-1:0] bAddr;
    // Register file and Q update enable
    logic writeEn;

    // Control FSM side
    modport ctrl (
        output instr,
        output aAddr,
        output bAddr,
        output writeEn
    );

    // Every bit slice reads the same copy
    modport slice (
        input instr,
        input aAddr,
        input bAddr,
        input writeEn
    );

endinterface

`default_nettype wire

// ==== design/bitSlice.sv ====
// One 4-bit 2901-style slice without tri-state output; registers and Q change only on edges with writeEn high
`timescale 1ns/1ps
`default_nettype none

module bitSlice (
    input  logic CLK,
    input  logic arstN,
    sliceCtrlIf.slice ctrl,
    input  logic [slicePkg::sliceWidth-1:0] d,
    input  logic cIn,
    input  logic ram0In,
    input  logic ram3In,
    input  logic q0In,
    input  logic q3In,
    output logic [slicePkg::sliceWidth-1:0] f,
    output logic [slicePkg::sliceWidth-1:0] y,
    output logic ram0Out,
    output logic ram3Out,
    output logic q0Out,
    output logic q3Out,
    output logic gBar,
    output logic pBar,
    output logic cOut,
    output logic ovr,
    output logic f3,
    output logic fZero
);
    import slicePkg::*;

    localparam int numWords = 2 ** regAddrWidth;

    // Two-port register file and Q
    logic [numWords-1:0][sliceWidth-1:0] ram;
    logic [sliceWidth-1:0] q;
    // Read ports and ALU operands
    logic [sliceWidth-1:0] aWord;
    logic [sliceWidth-1:0] bWord;
    logic [sliceWidth-1:0] r;
    logic [sliceWidth-1:0] s;
    // One extra bit on top catches the carry
    logic [sliceWidth:0] rExt;
    logic [sliceWidth:0] sExt;
    logic [sliceWidth:0] result;
    logic [sliceWidth-1:0] pTerm;
    logic [sliceWidth-1:0] gTerm;
    aluSrcE src;
    aluFuncE func;
    aluDestE dest;

    assign src  = aluSrcE'(ctrl.instr[2:0]);
    assign func = aluFuncE'(ctrl.instr[5:3]);
    assign dest = aluDestE'(ctrl.instr[8:6]);

    assign aWord = ram[ctrl.aAddr];
    assign bWord = ram[ctrl.bAddr];

    // R operand: A, D or zero
    always_comb begin
        case (src)
            srcAQ, srcAB: r = aWord;
            srcDA, srcDQ, srcDZ: r = d;
            default: r = '0;
        endcase
    end

    // S operand: Q, B, A or zero
    always_comb begin
        case (src)
            srcAQ, srcZQ, srcDQ: s = q;
            srcAB, srcZB: s = bWord;
            srcZA, srcDA: s = aWord;
            default: s = '0;
        endcase
    end

    // Subtraction inverts one side, carry-in supplies the +1
    assign rExt = (func == fnSubr) ? {1'b0, ~r} : {1'b0, r};
    assign sExt = (func == fnSubs) ? {1'b0, ~s} : {1'b0, s};

    always_comb begin
        case (func)
            fnAdd, fnSubr, fnSubs: result = rExt + sExt + {{sliceWidth{1'b0}}, cIn};
            fnOr: result = rExt | sExt;
            fnAnd: result = rExt & sExt;
            fnNotRs: result = ~rExt & sExt;
            fnExor: result = rExt ^ sExt;
            default: result = ~rExt ^ sExt;
        endcase
    end

    assign f     = result[sliceWidth-1:0];
    assign cOut  = result[sliceWidth];
    assign f3    = result[sliceWidth-1];
    assign fZero = ~|f;
    // Sign overflow: operands agree in sign, result does not
    assign ovr = ~(rExt[sliceWidth-1] ^ sExt[sliceWidth-1])
               & (rExt[sliceWidth-1] ^ result[sliceWidth-1]);

    // Lookahead terms on the possibly inverted operands
    assign pTerm = rExt[sliceWidth-1:0] | sExt[sliceWidth-1:0];
    assign gTerm = rExt[sliceWidth-1:0] & sExt[sliceWidth-1:0];
    assign pBar  = ~&pTerm;
    // Group generate, standard form
    assign gBar = ~(gTerm[3]
                  | (pTerm[3] & gTerm[2])
                  | (&pTerm[3:2] & gTerm[1])
                  | (&pTerm[3:1] & gTerm[0]));

    // RAMA passes A out, everything else shows F
    assign y = (dest == dstRamA) ? aWord : f;

    // Shift links to the neighbouring slices
    assign ram0Out = f[0];
    assign ram3Out = f[sliceWidth-1];
    assign q0Out   = q[0];
    assign q3Out   = q[sliceWidth-1];

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            ram <= '0;
            q   <= '0;
        end else if (ctrl.writeEn) begin
            // Register file write at the B address
            case (dest)
                dstRamA, dstRamF: ram[ctrl.bAddr] <= f;
                dstRamQD, dstRamD: ram[ctrl.bAddr] <= {ram3In, f[sliceWidth-1:1]};
                dstRamQU, dstRamU: ram[ctrl.bAddr] <= {f[sliceWidth-2:0], ram0In};
                default: ;
            endcase
            // Q load or shift
            case (dest)
                dstQReg: q <= f;
                dstRamQD: q <= {q3In, q[sliceWidth-1:1]};
                dstRamQU: q <= {q[sliceWidth-2:0], q0In};
                default: ;
            endcase
        end
    end

    // Storage moves only on the control FSM's execute strobe
    noWriteWhenIdle: assert property (@(posedge CLK) disable iff (!arstN)
        !ctrl.writeEn |=> ($stable(ram) && $stable(q)));

endmodule

`default_nettype wire

// ==== design/carryLookahead.sv ====
// Single-level lookahead over all slices; its carries only carry meaning for arithmetic functions
`timescale 1ns/1ps
`default_nettype none

module carryLookahead #(
    parameter int numSlices = 4
) (
    input  logic [numSlices-1:0] gBar,
    input  logic [numSlices-1:0] pBar,
    input  logic cIn,
    output logic [numSlices-1:0] carries,
    output logic cOut
);

    logic [numSlices-1:0] g;
    logic [numSlices-1:0] p;
    // Index k is the carry into slice k, top index is the word carry
    logic [numSlices:0] allCarry;
    logic [numSlices:0] rippleCarry;

    assign g = ~gBar;
    assign p = ~pBar;

    // Each carry is a flat sum of products, no carry feeds another
    always_comb begin
        logic term;
        allCarry = '0;
        for (int k = 0; k <= numSlices; k++) begin
            // Carry-in propagated through every lower slice
            term = cIn;
            for (int i = 0; i < k; i++) begin
                term = term & p[i];
            end
            allCarry[k] = term;
            // Slice j generates, all slices between propagate
            for (int j = 0; j < k; j++) begin
                term = g[j];
                for (int i = j + 1; i < k; i++) begin
                    term = term & p[i];
                end
                allCarry[k] = allCarry[k] | term;
            end
        end
    end

    assign carries = allCarry[numSlices-1:0];
    assign cOut    = allCarry[numSlices];

    // Slow ripple form, only for checking
    always_comb begin
        rippleCarry[0] = cIn;
        for (int k = 0; k < numSlices; k++) begin
            rippleCarry[k+1] = g[k] | (p[k] & rippleCarry[k]);
        end
    end

    // Lowest slice sees cIn and every upper carry matches a ripple
    always_comb begin
        lookaheadMatchesRipple: assert final (allCarry == rippleCarry);
    end

endmodule

`default_nettype wire

// ==== design/microControl.sv ====
// Four-phase req/ack sequencer running each microword once; the host must hold its inputs stable while req is high
`timescale 1ns/1ps
`default_nettype none

module microControl #(
    parameter int numSlices = 4
) (
    input  logic CLK,
    input  logic arstN,
    input  logic req,
    output logic ack,
    input  logic [slicePkg::instrWidth-1:0] instr,
    input  logic [slicePkg::regAddrWidth-1:0] aAddr,
    input  logic [slicePkg::regAddrWidth-1:0] bAddr,
    input  logic [numSlices*slicePkg::sliceWidth-1:0] dataIn,
    input  logic carryIn,
    sliceCtrlIf.ctrl ctrl,
    output logic [numSlices*slicePkg::sliceWidth-1:0] dataLatched,
    output logic carryLatched,
    input  logic [numSlices*slicePkg::sliceWidth-1:0] sliceY,
    input  logic sliceCarry,
    input  logic sliceOvr,
    input  logic sliceSign,
    input  logic sliceZero,
    output logic [numSlices*slicePkg::sliceWidth-1:0] dataOut,
    output slicePkg::statusFlagsT flags
);

    typedef enum logic [1:0] {
        stIdle,
        stExec,
        stDone
    } ctrlStateE;

    ctrlStateE state;
    ctrlStateE stateNext;
    // New request accepted this cycle
    logic latchEn;

    // Requests only count in IDLE with ack already low
    assign latchEn = (state == stIdle) && req && !ack;

    always_comb begin
        stateNext = state;
        case (state)
            stIdle: begin
                if (latchEn) begin
                    stateNext = stExec;
                end
            end
            // Exactly one execute cycle
            stExec: stateNext = stDone;
            // Held req parks the FSM here
            stDone: begin
                if (!req) begin
                    stateNext = stIdle;
                end
            end
            default: stateNext = stIdle;
        endcase
    end

    // The strobe is the EXEC state itself
    assign ctrl.writeEn = (state == stExec);

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            state   <= stIdle;
            ack     <= 1'b0;
            dataOut <= '0;
            flags   <= '0;
        end else begin
            state <= stateNext;
            if (state == stExec) begin
                // Result and flags captured on the same edge as the writes
                ack     <= 1'b1;
                dataOut <= sliceY;
                flags   <= '{carry: sliceCarry, overflow: sliceOvr,
                             zero: sliceZero, sign: sliceSign};
            end else if (state == stDone && !req) begin
                ack <= 1'b0;
            end
        end
    end

    // Latched microword, data word and carry-in for the slices and the lookahead
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            ctrl.instr   <= '0;
            ctrl.aAddr   <= '0;
            ctrl.bAddr   <= '0;
            dataLatched  <= '0;
            carryLatched <= 1'b0;
        end else if (latchEn) begin
            ctrl.instr   <= instr;
            ctrl.aAddr   <= aAddr;
            ctrl.bAddr   <= bAddr;
            dataLatched  <= dataIn;
            carryLatched <= carryIn;
        end
    end

    // ack rises only on an edge where the host was requesting
    ackNeedsReq: assert property (@(posedge CLK) disable iff (!arstN)
        $rose(ack) |-> $past(req));

    // One write per request, never back to back
    singleStrobe: assert property (@(posedge CLK) disable iff (!arstN)
        ctrl.writeEn |=> !ctrl.writeEn);

endmodule

`default_nettype wire

// ==== design/slice16Top.sv ====
// 16-bit unit of four slices with no output enable; carryOut and overflow are valid only after arithmetic functions
`timescale 1ns/1ps
`default_nettype none

module slice16Top #(
    parameter int numSlices = 4
) (
    input  logic CLK,
    input  logic arstN,
    input  logic req,
    output logic ack,
    input  logic [slicePkg::instrWidth-1:0] instr,
    input  logic [slicePkg::regAddrWidth-1:0] aAddr,
    input  logic [slicePkg::regAddrWidth-1:0] bAddr,
    input  logic [numSlices*slicePkg::sliceWidth-1:0] dataIn,
    input  logic carryIn,
    input  logic ramLsbIn,
    input  logic ramMsbIn,
    input  logic qLsbIn,
    input  logic qMsbIn,
    output logic [numSlices*slicePkg::sliceWidth-1:0] dataOut,
    output logic carryOut,
    output logic overflow,
    output logic zero,
    output logic sign
);
    import slicePkg::*;

    sliceCtrlIf ctrlIf ();

    // Word-wide buses built from the slice nibbles
    logic [numSlices*sliceWidth-1:0] dataLatched;
    logic [numSlices*sliceWidth-1:0] wordY;
    logic carryLatched;
    logic wordCarry;
    logic [numSlices-1:0] carries;
    // Per-slice status
    logic [numSlices-1:0] sliceGBar;
    logic [numSlices-1:0] slicePBar;
    logic [numSlices-1:0] sliceCOut;
    logic [numSlices-1:0] sliceOvr;
    logic [numSlices-1:0] sliceF3;
    logic [numSlices-1:0] sliceZero;
    // Shift links, one bit per slice
    logic [numSlices-1:0] ram0Out;
    logic [numSlices-1:0] ram3Out;
    logic [numSlices-1:0] q0Out;
    logic [numSlices-1:0] q3Out;
    logic [numSlices-1:0] ram0In;
    logic [numSlices-1:0] ram3In;
    logic [numSlices-1:0] q0In;
    logic [numSlices-1:0] q3In;
    statusFlagsT flags;

    // Down shift takes the next slice up, MSB fill at the top
    assign ram3In = {ramMsbIn, ram0Out[numSlices-1:1]};
    assign q3In   = {qMsbIn, q0Out[numSlices-1:1]};
    // Up shift takes the next slice down, LSB fill at the bottom
    assign ram0In = {ram3Out[numSlices-2:0], ramLsbIn};
    assign q0In   = {q3Out[numSlices-2:0], qLsbIn};

    microControl #(.numSlices(numSlices)) control (
        .CLK,
        .arstN,
        .req,
        .ack,
        .instr,
        .aAddr,
        .bAddr,
        .dataIn,
        .carryIn,
        .ctrl(ctrlIf.ctrl),
        .dataLatched,
        .carryLatched,
        .sliceY(wordY),
        .sliceCarry(wordCarry),
        .sliceOvr(sliceOvr[numSlices-1]),
        .sliceSign(sliceF3[numSlices-1]),
        .sliceZero(&sliceZero),
        .dataOut,
        .flags
    );

    carryLookahead #(.numSlices(numSlices)) lookahead (
        .gBar(sliceGBar),
        .pBar(slicePBar),
        .cIn(carryLatched),
        .carries,
        .cOut(wordCarry)
    );

    for (genvar k = 0; k < numSlices; k++) begin : sliceGen
        bitSlice slice (
            .CLK,
            .arstN,
            .ctrl(ctrlIf.slice),
            .d(dataLatched[k*sliceWidth +: sliceWidth]),
            .cIn(carries[k]),
            .ram0In(ram0In[k]),
            .ram3In(ram3In[k]),
            .q0In(q0In[k]),
            .q3In(q3In[k]),
            .f(),
            .y(wordY[k*sliceWidth +: sliceWidth]),
            .ram0Out(ram0Out[k]),
            .ram3Out(ram3Out[k]),
            .q0Out(q0Out[k]),
            .q3Out(q3Out[k]),
            .gBar(sliceGBar[k]),
            .pBar(slicePBar[k]),
            .cOut(sliceCOut[k]),
            .ovr(sliceOvr[k]),
            .f3(sliceF3[k]),
            .fZero(sliceZero[k])
        );
    end

    assign carryOut = flags.carry;
    assign overflow = flags.overflow;
    assign zero     = flags.zero;
    assign sign     = flags.sign;

    // Lookahead carries equal each slice's own ripple carry-out
    carryChainAgrees: assert property (@(posedge CLK) disable iff (!arstN)
        (ctrlIf.writeEn && (ctrlIf.instr[5:3] inside {fnAdd, fnSubr, fnSubs}))
        |-> ({wordCarry, carries[numSlices-1:1]} == sliceCOut));

endmodule

`default_nettype wire

// ==== testbench/sliceRefModel.svh ====
// Word-level 2901 model for a 16-bit unit; carry and overflow are only modeled for arithmetic functions
`ifndef SLICE_REF_MODEL_SVH
`define SLICE_REF_MODEL_SVH

// Mirror of the register file and Q
logic [15:0] modelRam [16];
logic [15:0] modelQ;

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// One microword against the model, storage updated in place
task automatic modelExec(
    input logic [instrWidth-1:0] ins,
    input logic [3:0] a,
    input logic [3:0] b,
    input logic [15:0] d,
    input logic cin,
    input logic ramLsb,
    input logic ramMsb,
    input logic qLsb,
    input logic qMsb,
    output logic [15:0] y,
    output statusFlagsT fl
);
    logic [15:0] r;
    logic [15:0] s;
    logic [15:0] opR;
    logic [15:0] opS;
    logic [15:0] fw;
    logic [16:0] sum;
    logic signed [16:0] wide;
    aluSrcE src;
    aluFuncE fn;
    aluDestE dst;
    src = aluSrcE'(ins[2:0]);
    fn  = aluFuncE'(ins[5:3]);
    dst = aluDestE'(ins[8:6]);
    // R is A for AQ and AB, D for the three D sources, zero otherwise
    r = (src inside {srcAQ, srcAB}) ? modelRam[a] : (src inside {srcDA, srcDQ, srcDZ}) ? d : '0;
    // S is Q, B, A or zero
    s = (src inside {srcAQ, srcZQ, srcDQ}) ? modelQ
      : (src inside {srcAB, srcZB}) ? modelRam[b]
      : (src inside {srcZA, srcDA}) ? modelRam[a] : '0;
    // Subtraction as one's complement plus carry-in
    opR  = (fn == fnSubr) ? ~r : r;
    opS  = (fn == fnSubs) ? ~s : s;
    sum  = {1'b0, opR} + {1'b0, opS} + 17'(cin);
    wide = $signed({opR[15], opR}) + $signed({opS[15], opS}) + $signed({16'b0, cin});
    fl = '0;
    case (fn)
        fnAdd, fnSubr, fnSubs: begin
            fw = sum[15:0];
            fl.carry = sum[16];
            // Signed result does not fit in 16 bits
            fl.overflow = wide[16] ^ wide[15];
        end
        fnOr: fw = r | s;
        fnAnd: fw = r & s;
        fnNotRs: fw = ~r & s;
        fnExor: fw = r ^ s;
        default: fw = ~(r ^ s);
    endcase
    fl.zero = (fw == 16'h0);
    fl.sign = fw[15];
    y = (dst == dstRamA) ? modelRam[a] : fw;
    case (dst)
        dstRamA, dstRamF: modelRam[b] = fw;
        dstRamQD, dstRamD: modelRam[b] = {ramMsb, fw[15:1]};
        dstRamQU, dstRamU: modelRam[b] = {fw[14:0], ramLsb};
        default: ;
    endcase
    case (dst)
        dstQReg: modelQ = fw;
        dstRamQD: modelQ = {qMsb, modelQ[15:1]};
        dstRamQU: modelQ = {modelQ[14:0], qLsb};
        default: ;
    endcase
endtask

`endif

// ==== testbench/slice16Tb.sv ====
// Self-checking bench for slice16Top; every handshake wait gives up after 50 cycles
`timescale 1ns/1ps
`default_nettype none

module slice16Tb;
    import slicePkg::*;

    localparam int numSlices = 4;
    localparam int timeoutCycles = 50;

    logic CLK;
    logic arstN;
    logic req;
    logic ack;
    logic [instrWidth-1:0] instr;
    logic [regAddrWidth-1:0] aAddr;
    logic [regAddrWidth-1:0] bAddr;
    logic [15:0] dataIn;
    logic carryIn;
    logic ramLsbIn;
    logic ramMsbIn;
    logic qLsbIn;
    logic qMsbIn;
    logic [15:0] dataOut;
    logic carryOut;
    logic overflow;
    logic zero;
    logic sign;

    int errorCount;
    int checkCount;
    logic [31:0] lfsrState;
    // Last sampled DUT result and the model's prediction
    logic [15:0] gotData;
    logic [15:0] expData;
    statusFlagsT gotFlags;
    statusFlagsT expFlags;

    `include "sliceRefModel.svh"

    slice16Top #(.numSlices(numSlices)) dut_i (
        .CLK,
        .arstN,
        .req,
        .ack,
        .instr,
        .aAddr,
        .bAddr,
        .dataIn,
        .carryIn,
        .ramLsbIn,
        .ramMsbIn,
        .qLsbIn,
        .qMsbIn,
        .dataOut,
        .carryOut,
        .overflow,
        .zero,
        .sign
    );

    always #2 CLK = ~CLK;

    // Protocol checks
    ackOnlyWithReq: assert property (@(posedge CLK) disable iff (!arstN)
        $rose(ack) |-> $past(req))
        else begin
            errorCount++;
            $display("ack rose while req was low");
        end
    resultHeld: assert property (@(posedge CLK) disable iff (!arstN)
        (ack && req) |=> (ack && $stable(dataOut) && $stable({carryOut, overflow, zero, sign})))
        else begin
            errorCount++;
            $display("ack or the outputs changed while req was held high");
        end
    ackFollowsReq: assert property (@(posedge CLK) disable iff (!arstN)
        (ack && !req) |=> !ack)
        else begin
            errorCount++;
            $display("ack stayed high after req dropped");
        end

    // Next n LFSR bits, one step per bit
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic logic [instrWidth-1:0] makeInstr(
        input aluDestE dst, input aluFuncE fn, input aluSrcE src);
        return {dst, fn, src};
    endfunction

    task automatic abortRun(input string reason);
        $display("Timeout: %s within %0d cycles", reason, timeoutCycles);
        $display("SIMULATION FAILED");
        $finish;
    endtask

    task automatic checkEqual(input string testName, input logic [15:0] expected,
                              input logic [15:0] actual);
        checkCount++;
        valueMatches: assert (actual === expected)
            else begin
                errorCount++;
                $display("FAIL %s expected %h actual %h", testName, expected, actual);
            end
    endtask

    // fills is {ramMsbIn, ramLsbIn, qMsbIn, qLsbIn}
    task automatic doOp(input logic [instrWidth-1:0] ins, input logic [3:0] a,
                        input logic [3:0] b, input logic [15:0] d, input logic cin,
                        input logic [3:0] fills, input int holdCycles);
        int waited;
        @(negedge CLK);
        instr    = ins;
        aAddr    = a;
        bAddr    = b;
        dataIn   = d;
        carryIn  = cin;
        ramMsbIn = fills[3];
        ramLsbIn = fills[2];
        qMsbIn   = fills[1];
        qLsbIn   = fills[0];
        req      = 1'b1;
        waited   = 0;
        while (ack !== 1'b1) begin
            @(negedge CLK);
            waited++;
            if (waited > timeoutCycles) abortRun("ack did not rise");
        end
        // Registered outputs are settled at the falling edge
        gotData  = dataOut;
        gotFlags = {carryOut, overflow, zero, sign};
        modelExec(ins, a, b, d, cin, fills[2], fills[3], fills[0], fills[1], expData, expFlags);
        repeat (holdCycles) @(negedge CLK);
        req = 1'b0;
        waited = 0;
        while (ack !== 1'b0) begin
            @(negedge CLK);
            waited++;
            if (waited > timeoutCycles) abortRun("ack did not fall");
        end
    endtask

    // RAMA shows A and rewrites the same word
    task automatic readReg(input logic [3:0] r);
        doOp(makeInstr(dstRamA, fnOr, srcZA), r, r, 16'h0, 1'b0, 4'b0, 0);
    endtask

    task automatic readQ();
        doOp(makeInstr(dstNop, fnOr, srcZQ), 4'd0, 4'd0, 16'h0, 1'b0, 4'b0, 0);
    endtask

    task automatic endTest(input string name, input int errStart, input int chkStart);
        $display("test %-12s checks %0d errors %0d", name, checkCount - chkStart,
                 errorCount - errStart);
    endtask

    initial begin
        int e0;
        int c0;
        logic [15:0] loaded [16];
        logic [15:0] snapshot [16];
        logic [15:0] word;
        logic [15:0] ramBack;
        logic [3:0] a;
        logic [3:0] b;
        logic [3:0] fills;
        logic cin;
        aluDestE dst;
        aluFuncE fn;
        aluSrcE src;
        CLK = 1'b0;
        arstN = 1'b0;
        req = 1'b0;
        instr = '0;
        aAddr = '0;
        bAddr = '0;
        dataIn = '0;
        carryIn = 1'b0;
        ramLsbIn = 1'b0;
        ramMsbIn = 1'b0;
        qLsbIn = 1'b0;
        qMsbIn = 1'b0;
        errorCount = 0;
        checkCount = 0;
        lfsrState = 32'hc717b9db;
        modelQ = '0;
        foreach (modelRam[k]) modelRam[k] = '0;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        arstN = 1'b1;

        e0 = errorCount;
        c0 = checkCount;
        checkCount++;
        ackLowAfterReset: assert (ack === 1'b0)
            else begin
                errorCount++;
                $display("ack is high after reset");
            end
        endTest("reset", e0, c0);

        // Load every register through D, then read each back at A
        e0 = errorCount;
        c0 = checkCount;
        for (int k = 0; k < 16; k++) begin
            loaded[k] = 16'(takeBits(16));
            doOp(makeInstr(dstRamF, fnOr, srcDZ), 4'(k), 4'(k), loaded[k], 1'b0, 4'b0, 0);
            checkEqual("load", loaded[k], gotData);
        end
        for (int k = 0; k < 16; k++) begin
            readReg(4'(k));
            checkEqual("readback", loaded[k], gotData);
        end
        endTest("load", e0, c0);

        e0 = errorCount;
        c0 = checkCount;
        for (int k = 0; k < 30; k++) begin
            fn   = aluFuncE'(k % 3);
            src  = (k % 2 == 1) ? srcDA : srcAB;
            a    = 4'(takeBits(4));
            b    = 4'(takeBits(4));
            word = 16'(takeBits(16));
            cin  = 1'(takeBits(1));
            doOp(makeInstr(dstRamF, fn, src), a, b, word, cin, 4'b0, 0);
            checkEqual("arith data", expData, gotData);
            checkEqual("arith flags", 16'(expFlags), 16'(gotFlags));
        end
        // R minus itself with carry-in is exactly zero
        doOp(makeInstr(dstNop, fnSubs, srcAB), 4'd3, 4'd3, 16'h0, 1'b1, 4'b0, 0);
        checkEqual("arith zero", 16'd1, 16'(gotFlags.zero));
        checkEqual("arith zero flags", 16'(expFlags), 16'(gotFlags));
        endTest("arith", e0, c0);

        e0 = errorCount;
        c0 = checkCount;
        for (int k = 0; k < 25; k++) begin
            fn   = aluFuncE'(3 + k % 5);
            src  = aluSrcE'(3'(takeBits(3)));
            dst  = (k % 4 == 3) ? dstQReg : dstRamF;
            a    = 4'(takeBits(4));
            b    = 4'(takeBits(4));
            word = 16'(takeBits(16));
            doOp(makeInstr(dst, fn, src), a, b, word, 1'b0, 4'b0, 0);
            checkEqual("logic data", expData, gotData);
            checkEqual("logic zero sign", {expFlags.zero, expFlags.sign},
                       {gotFlags.zero, gotFlags.sign});
        end
        endTest("logic", e0, c0);

        e0 = errorCount;
        c0 = checkCount;
        for (int k = 0; k < 16; k++) begin
            dst   = aluDestE'(4 + k / 4);
            a     = 4'(takeBits(4));
            b     = 4'(takeBits(4));
            fills = 4'(takeBits(4));
            doOp(makeInstr(dst, fnExor, srcAB), a, b, 16'h0, 1'b0, fills, 0);
            checkEqual("shift data", expData, gotData);
            readReg(b);
            ramBack = gotData;
            checkEqual("shift ram", modelRam[b], ramBack);
            // Fill bit lands at the vacated end
            if (dst inside {dstRamQD, dstRamD}) begin
                checkEqual("shift ram msb", 16'(fills[3]), 16'(ramBack[15]));
            end else begin
                checkEqual("shift ram lsb", 16'(fills[2]), 16'(ramBack[0]));
            end
            readQ();
            checkEqual("shift q", modelQ, gotData);
            if (dst == dstRamQD) begin
                checkEqual("shift q msb", 16'(fills[1]), 16'(gotData[15]));
            end else if (dst == dstRamQU) begin
                checkEqual("shift q lsb", 16'(fills[0]), 16'(gotData[0]));
            end
        end
        endTest("shift", e0, c0);

        // Held req must not repeat the ADD
        e0 = errorCount;
        c0 = checkCount;
        word = 16'(takeBits(16));
        doOp(makeInstr(dstRamF, fnOr, srcDZ), 4'd5, 4'd5, word, 1'b0, 4'b0, 0);
        doOp(makeInstr(dstRamF, fnAdd, srcDA), 4'd5, 4'd5, 16'd1, 1'b0, 4'b0, 20);
        readReg(4'd5);
        checkEqual("held add", word + 16'd1, gotData);
        // Inputs wander while req stays low
        snapshot = modelRam;
        for (int k = 0; k < 10; k++) begin
            @(negedge CLK);
            instr  = 9'(takeBits(9));
            aAddr  = 4'(takeBits(4));
            bAddr  = 4'(takeBits(4));
            dataIn = 16'(takeBits(16));
        end
        for (int k = 0; k < 16; k++) begin
            readReg(4'(k));
            checkEqual("idle", snapshot[k], gotData);
        end
        endTest("handshake", e0, c0);

        repeat (2) @(negedge CLK);
        $display("all tests done: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== slice16.f ====
+incdir+testbench
design/slicePkg.sv
design/sliceCtrlIf.sv
design/bitSlice.sv
design/carryLookahead.sv
design/microControl.sv
design/slice16Top.sv
testbench/slice16Tb.sv

// ==== Bender.yml ====
package:
  name: slice16

sources:
  - files:
      - design/slicePkg.sv
      - design/sliceCtrlIf.sv
      - design/bitSlice.sv
      - design/carryLookahead.sv
      - design/microControl.sv
      - design/slice16Top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/slice16Tb.sv
